// ==== common/ifu_defs.svh ====
// ICCM size, DMA tag width and aligner queue sizing macros
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// ********************
// ICCM geometry
// ********************

// Word index bits, 256 words of 32 bits
`define IFU_ICCM_AW    8

// ********************
// DMA port
// ********************

`define IFU_DMA_TAG_W  3   // DMA buffer entry number

// ********************
// Aligner queue
// ********************

// Queue capacity in halfwords, three fetch words
`define IFU_ALN_DEPTH  6

// Holds counts 0 to IFU_ALN_DEPTH
`define IFU_ALN_CNT_W  3

`endif

// ==== common/ifu_pkg.sv ====
// Shared fetch word union, ICCM request, DMA request and fetch packet types
`include "ifu_defs.svh"

package ifu_pkg;

   // ********************
   // Fetch word views
   // ********************

   typedef struct packed {
      logic [15:0] hi;                        // Upper parcel, PC + 2
      logic [15:0] lo;                        // Lower parcel, word-aligned PC
   } fetch_hw_t;

   typedef union packed {
      logic [31:0] raw;                       // Memory and arbiter view
      fetch_hw_t   hw;                        // Aligner view
   } fetch_word_u;

   // ********************
   // Requests and packets
   // ********************

   typedef struct packed {
      logic                    valid;
      logic                    write;         // Else read
      logic [`IFU_ICCM_AW-1:0] idx;           // Word index
      logic [3:0]              be;            // Byte lanes for writes
      fetch_word_u             data;          // Lane-aligned write data
   } iccm_req_t;

   typedef struct packed {
      logic                      valid;       // Single-cycle strobe
      logic                      write;
      logic [31:0]               addr;        // Byte address
      logic [1:0]                size;        // 0 byte, 1 half, 2 word
      logic [`IFU_DMA_TAG_W-1:0] tag;         // Returned with read data
      logic [31:0]               wdata;       // Right-justified
   } dma_req_t;

   typedef struct packed {
      logic        valid;
      logic        skip_lo;                   // Target had PC bit 1 set
      fetch_word_u word;
   } fetch_pkt_t;

endpackage

// ==== hw/fetch/ifu_ifc_ctl.sv ====
// Fetch controller with word address, request issue and stale response filter
`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_ifc_ctl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      exu_flush_final,       // Redirect strobe
   input  logic [31:1]               exu_flush_path_final,  // Redirect target
   input  logic [`IFU_ALN_CNT_W-1:0] aln_free,              // Free aligner halfwords
   input  logic                      fetch_gnt,             // Arbiter accepted request
   input  logic                      fetch_rvalid,          // Read data returning
   input  ifu_pkg::fetch_word_u      fetch_rdata,
   output logic                      fetch_req_valid,
   output logic [`IFU_ICCM_AW-1:0]   fetch_word_idx,
   output ifu_pkg::fetch_pkt_t       fetch_pkt
);

   localparam int CW = `IFU_ALN_CNT_W;

   logic [`IFU_ICCM_AW-1:0] fetch_addr;                     // Next word to fetch
   logic                    active;                         // Set by first flush
   logic                    outstanding;                    // Granted last cycle
   logic                    stale;                          // In flight across a flush
   logic                    skip_pend;                      // Drop low half of next word
   logic [CW-1:0]           space_need;
   logic                    pkt_ok;

   // ********************
   // Request issue
   // ********************

   // Room for this word plus the one still returning
   assign space_need      = outstanding ? CW'(4) : CW'(2);
   assign fetch_req_valid = active & (aln_free >= space_need);
   assign fetch_word_idx  = fetch_addr;

   // ********************
   // Response forwarding
   // ********************

   assign pkt_ok            = fetch_rvalid & ~stale & ~exu_flush_final; // Old stream dropped
   assign fetch_pkt.valid   = pkt_ok;
   assign fetch_pkt.skip_lo = skip_pend;
   assign fetch_pkt.word    = fetch_rdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_addr  <= '0;
         active      <= 1'b0;
         outstanding <= 1'b0;
         stale       <= 1'b0;
         skip_pend   <= 1'b0;
      end else begin
         outstanding <= fetch_gnt;                          // One-cycle read latency
         stale       <= exu_flush_final & fetch_gnt;        // Old address granted on flush
         if (exu_flush_final) begin
            fetch_addr <= exu_flush_path_final[`IFU_ICCM_AW+1:2];
            active     <= 1'b1;
            skip_pend  <= exu_flush_path_final[1];          // Start mid-word
         end else begin
            if (fetch_gnt) begin
               fetch_addr <= fetch_addr + 1'b1;             // Sequential next word
            end
            if (pkt_ok) begin
               skip_pend <= 1'b0;                           // Only first word after flush
            end
         end
      end
   end

endmodule

// ==== hw/fetch/ifu_aln_ctl.sv ====
// Aligner with halfword queue, instruction length decode and decode-side outputs
`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_aln_ctl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      exu_flush_final,       // Empty queue, reload PC
   input  logic [31:1]               exu_flush_path_final,
   input  ifu_pkg::fetch_pkt_t       fetch_pkt,             // Word from fetch control
   input  logic                      dec_i0_decode_d,       // Decode takes current instr
   output logic [`IFU_ALN_CNT_W-1:0] aln_free,
   output logic                      ifu_i0_valid,
   output logic [31:0]               ifu_i0_instr,
   output logic [31:1]               ifu_i0_pc,
   output logic                      ifu_i0_pc4
);

   import ifu_pkg::*;

   localparam int            CW    = `IFU_ALN_CNT_W;
   localparam logic [CW-1:0] DEPTH = CW'(`IFU_ALN_DEPTH);

   logic [15:0]   q [`IFU_ALN_DEPTH];                       // Halfword ring
   logic [CW-1:0] head;                                     // Oldest halfword
   logic [CW-1:0] cnt;                                      // Halfwords held
   logic [CW-1:0] head1;
   logic [CW-1:0] wr_ptr;
   logic [CW-1:0] wr_ptr1;
   logic [CW-1:0] push_n;
   logic [CW-1:0] pop_n;
   logic [31:1]   head_pc;                                  // PC of head halfword
   logic [15:0]   hw0;
   logic [15:0]   hw1;
   logic          is32;
   logic          push;
   logic          take;
   fetch_word_u   in_word;

   // Ring index add, modulo queue depth
   function automatic logic [CW-1:0] q_wrap(input logic [CW-1:0] p, input logic [CW-1:0] n);
      logic [CW:0] s;
      s = {1'b0, p} + {1'b0, n};
      if (s >= {1'b0, DEPTH}) begin
         s = s - {1'b0, DEPTH};
      end
      return s[CW-1:0];
   endfunction

   // ********************
   // Queue pointers
   // ********************

   assign in_word = fetch_pkt.word;
   assign push    = fetch_pkt.valid & ~exu_flush_final;
   assign push_n  = !push ? CW'(0) : (fetch_pkt.skip_lo ? CW'(1) : CW'(2));
   assign head1   = q_wrap(head, CW'(1));
   assign wr_ptr  = q_wrap(head, cnt);                      // First empty slot
   assign wr_ptr1 = q_wrap(wr_ptr, CW'(1));
   assign aln_free = DEPTH - cnt;                           // Pops this cycle not counted

   // ********************
   // Length decode and output
   // ********************

   assign hw0  = q[head];
   assign hw1  = q[head1];
   assign is32 = &hw0[1:0];                                 // 2'b11 means not compressed

   assign ifu_i0_valid = ~exu_flush_final & (is32 ? (cnt >= CW'(2)) : (cnt != '0));
   assign ifu_i0_instr = is32 ? {hw1, hw0} : {16'h0000, hw0};
   assign ifu_i0_pc    = head_pc;
   assign ifu_i0_pc4   = is32;

   assign take  = ifu_i0_valid & dec_i0_decode_d;
   assign pop_n = !take ? CW'(0) : (is32 ? CW'(2) : CW'(1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head    <= '0;
         cnt     <= '0;
         head_pc <= '0;
      end else if (exu_flush_final) begin
         head    <= '0;
         cnt     <= '0;                                     // Discard old stream
         head_pc <= exu_flush_path_final;
      end else begin
         head <= q_wrap(head, pop_n);
         cnt  <= cnt + push_n - pop_n;
         if (take) begin
            head_pc <= head_pc + (is32 ? 31'd2 : 31'd1);    // 4 or 2 bytes
         end
      end
   end

   // Queue storage
   always_ff @(posedge clk) begin
      if (push) begin
         if (fetch_pkt.skip_lo) begin
            q[wr_ptr] <= in_word.hw.hi;                     // Target was PC + 2
         end else begin
            q[wr_ptr]  <= in_word.hw.lo;
            q[wr_ptr1] <= in_word.hw.hi;
         end
      end
   end

endmodule

// ==== hw/iccm/iccm_arb.sv ====
// ICCM arbiter with DMA priority, byte lane steering and read return routing
`timescale 1ns/1ps
`include "ifu_defs.svh"

module iccm_arb (
   input  logic                      clk,
   input  logic                      rst_n,
   input  ifu_pkg::dma_req_t         dma_req,
   input  logic                      fetch_req_valid,
   input  logic [`IFU_ICCM_AW-1:0]   fetch_word_idx,
   output logic                      fetch_gnt,
   output ifu_pkg::iccm_req_t        mem_req,
   input  ifu_pkg::fetch_word_u      rd_word,               // One cycle after grant
   output logic                      fetch_rvalid,
   output ifu_pkg::fetch_word_u      fetch_rdata,
   output logic                      iccm_dma_rvalid,
   output logic [31:0]               iccm_dma_rdata,
   output logic [`IFU_DMA_TAG_W-1:0] iccm_dma_rtag
);

   import ifu_pkg::*;

   logic                      dma_rd;
   logic                      dma_wr;
   logic [3:0]                dma_be;
   fetch_word_u               dma_wdata;                    // Shifted into its lanes
   logic                      dma_rd_q;                     // DMA owns read in flight
   logic                      fetch_rd_q;                   // Fetch owns read in flight
   logic [`IFU_DMA_TAG_W-1:0] tag_q;

   assign dma_rd    = dma_req.valid & ~dma_req.write;
   assign dma_wr    = dma_req.valid & dma_req.write;
   assign fetch_gnt = fetch_req_valid & ~dma_req.valid;     // DMA always wins

   // ********************
   // Byte lane steering
   // ********************

   always_comb begin
      case (dma_req.size)
         2'd0: begin
            dma_be        = 4'b0001 << dma_req.addr[1:0];
            dma_wdata.raw = {24'h0, dma_req.wdata[7:0]} << {dma_req.addr[1:0], 3'b000};
         end
         2'd1: begin
            dma_be        = dma_req.addr[1] ? 4'b1100 : 4'b0011;
            dma_wdata.raw = {16'h0, dma_req.wdata[15:0]} << {dma_req.addr[1], 4'b0000};
         end
         default: begin
            dma_be        = 4'b1111;                        // Full word
            dma_wdata.raw = dma_req.wdata;
         end
      endcase
   end

   assign mem_req.valid = dma_req.valid | fetch_gnt;
   assign mem_req.write = dma_wr;
   assign mem_req.idx   = dma_req.valid ? dma_req.addr[`IFU_ICCM_AW+1:2] : fetch_word_idx;
   assign mem_req.be    = dma_wr ? dma_be : 4'b0000;
   assign mem_req.data  = dma_wdata;

   // ********************
   // Read return routing
   // ********************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dma_rd_q   <= 1'b0;
         fetch_rd_q <= 1'b0;
      end else begin
         dma_rd_q   <= dma_rd;
         fetch_rd_q <= fetch_gnt;
      end
   end

   always_ff @(posedge clk) begin
      if (dma_rd) begin
         tag_q <= dma_req.tag;                              // Echoed with data
      end
   end

   assign iccm_dma_rvalid = dma_rd_q;
   assign iccm_dma_rdata  = rd_word.raw;
   assign iccm_dma_rtag   = tag_q;
   assign fetch_rvalid    = fetch_rd_q;
   assign fetch_rdata     = rd_word;

endmodule

// ==== hw/iccm/iccm_mem.sv ====
// ICCM word array with byte lane writes and registered read
`timescale 1ns/1ps
`include "ifu_defs.svh"

module iccm_mem (
   input  logic                 clk,
   input  ifu_pkg::iccm_req_t   mem_req,                    // From arbiter
   output ifu_pkg::fetch_word_u rd_word                     // Valid one cycle after read
);

   localparam int WORDS = 1 << `IFU_ICCM_AW;

   logic [31:0] mem [WORDS];

   // ********************
   // Array access
   // ********************

   always_ff @(posedge clk) begin
      if (mem_req.valid & mem_req.write) begin
         for (int i = 0; i < 4; i++) begin
            if (mem_req.be[i]) begin
               mem[mem_req.idx][8*i +: 8] <= mem_req.data.raw[8*i +: 8]; // Lane i only
            end
         end
      end
      if (mem_req.valid & ~mem_req.write) begin
         rd_word.raw <= mem[mem_req.idx];                   // Held until next read
      end
   end

endmodule

// ==== hw/ifu_top.sv ====
// Fetch unit top with fetch control, aligner, ICCM arbiter and ICCM array
`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      exu_flush_final,       // Redirect strobe
   input  logic [31:1]               exu_flush_path_final,  // Redirect target
   input  logic                      dec_i0_decode_d,       // Decode takes instruction
   input  ifu_pkg::dma_req_t         dma_req,
   output logic                      iccm_dma_rvalid,
   output logic [31:0]               iccm_dma_rdata,
   output logic [`IFU_DMA_TAG_W-1:0] iccm_dma_rtag,
   output logic                      ifu_i0_valid,
   output logic [31:0]               ifu_i0_instr,
   output logic [31:1]               ifu_i0_pc,
   output logic                      ifu_i0_pc4             // 32-bit instruction
);

   import ifu_pkg::*;

   logic [`IFU_ALN_CNT_W-1:0] aln_free;                     // Aligner to fetch control
   logic                      fetch_req_valid;
   logic [`IFU_ICCM_AW-1:0]   fetch_word_idx;
   logic                      fetch_gnt;
   logic                      fetch_rvalid;
   fetch_word_u               fetch_rdata;
   fetch_pkt_t                fetch_pkt;                    // Fetch control to aligner
   iccm_req_t                 mem_req;
   fetch_word_u               rd_word;

   // ********************
   // Fetch path
   // ********************

   ifu_ifc_ctl ifc (.*);

   ifu_aln_ctl aln (.*);

   // ********************
   // ICCM and its sharing
   // ********************

   iccm_arb arb (.*);

   iccm_mem iccm (.*);

endmodule

// ==== dv/ifu_chk.sv ====
// Bound assertions on DMA read return, flush emptying, reset and decode stall
`timescale 1ns/1ps

module ifu_chk (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 exu_flush_final,
   input logic                 dec_i0_decode_d,
   input ifu_pkg::dma_req_t    dma_req,
   input logic                 iccm_dma_rvalid,
   input logic                 ifu_i0_valid,
   input logic [31:0]          ifu_i0_instr,
   input logic [31:1]          ifu_i0_pc,
   input logic                 ifu_i0_pc4
);

   // ********************
   // DMA return timing
   // ********************

   a_dma_rd_ret: assert property (@(posedge clk) disable iff (!rst_n)
      (dma_req.valid && !dma_req.write) |=> iccm_dma_rvalid)
      else $error("DMA read not answered one cycle after its request");

   a_dma_no_ret: assert property (@(posedge clk) disable iff (!rst_n)
      !(dma_req.valid && !dma_req.write) |=> !iccm_dma_rvalid)
      else $error("DMA read data returned without a read request");

   // ********************
   // Decode side
   // ********************

   // Old stream gone, new words not yet back
   a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
      exu_flush_final |=> !ifu_i0_valid)
      else $error("ifu_i0_valid high in the cycle after a flush");

   a_rst_quiet: assert property (@(posedge clk) !rst_n |-> !ifu_i0_valid)
      else $error("ifu_i0_valid high during reset");

   // Held instruction may only vanish on a redirect
   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (ifu_i0_valid && !dec_i0_decode_d && !exu_flush_final) |=>
      (exu_flush_final || (ifu_i0_valid && $stable(ifu_i0_instr) &&
                           $stable(ifu_i0_pc) && $stable(ifu_i0_pc4))))
      else $error("Instruction outputs changed while decode stalled");

endmodule

bind ifu_top ifu_chk i_chk (.*);

// ==== dv/ifu_tb.sv ====
// Fetch unit testbench with step table, ICCM shadow, reference stream and watchdog
`timescale 1ns/1ps
`include "ifu_defs.svh"

module ifu_tb;

   import ifu_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYC    = 4;
   localparam int ICCM_WORDS   = 1 << `IFU_ICCM_AW;
   localparam int TW           = `IFU_DMA_TAG_W;
   localparam int NSTEPS       = 22;
   localparam int STEP_CYC     = 60;                        // Budget per table step
   localparam int WATCHDOG_CYC = RESET_CYC + 2 * ICCM_WORDS + NSTEPS * STEP_CYC;

   localparam logic [1:0] K_WR    = 2'd0;                   // DMA write
   localparam logic [1:0] K_RD    = 2'd1;                   // DMA read
   localparam logic [1:0] K_FETCH = 2'd2;                   // Flush then check stream

   typedef struct packed {
      logic [1:0]    kind;
      logic [31:0]   addr;                                  // Byte address or flush target
      logic [1:0]    size;                                  // DMA size, or decode mode
      logic [31:0]   data;
      logic [TW-1:0] tag;
      logic [31:0]   expv;                                  // Read data, or instr count
   } step_t;

   // Fetch modes: 0 decode always ready, 1 random stalls, 2 stalls plus DMA reads
   localparam step_t STEPS [NSTEPS] = '{
      '{K_WR,    32'h0000_0040, 2'd2, 32'h1234_5678, 3'd0, 32'h0},
      '{K_RD,    32'h0000_0040, 2'd2, 32'h0,         3'd5, 32'h1234_5678},
      '{K_WR,    32'h0000_0041, 2'd0, 32'h0000_00AB, 3'd0, 32'h0},
      '{K_WR,    32'h0000_0042, 2'd1, 32'h0000_C0DE, 3'd0, 32'h0},
      '{K_RD,    32'h0000_0040, 2'd2, 32'h0,         3'd2, 32'hC0DE_AB78},
      '{K_WR,    32'h0000_0044, 2'd2, 32'hDEAD_BEEF, 3'd0, 32'h0},
      '{K_WR,    32'h0000_0046, 2'd0, 32'h0000_0077, 3'd0, 32'h0},
      '{K_WR,    32'h0000_0044, 2'd1, 32'h0000_1111, 3'd0, 32'h0},
      '{K_RD,    32'h0000_0044, 2'd2, 32'h0,         3'd3, 32'hDE77_1111},
      '{K_WR,    32'h0000_0100, 2'd2, 32'h0513_4501, 3'd0, 32'h0},  // 16b, 32b start
      '{K_WR,    32'h0000_0104, 2'd2, 32'h852A_0010, 3'd0, 32'h0},  // 32b tail, 16b
      '{K_WR,    32'h0000_0108, 2'd2, 32'h0020_0093, 3'd0, 32'h0},  // Aligned 32b
      '{K_WR,    32'h0000_010C, 2'd2, 32'h4581_0505, 3'd0, 32'h0},
      '{K_WR,    32'h0000_0110, 2'd2, 32'h0001_1137, 3'd0, 32'h0},
      '{K_WR,    32'h0000_0114, 2'd2, 32'h0297_8082, 3'd0, 32'h0},
      '{K_WR,    32'h0000_0118, 2'd2, 32'h0001_0000, 3'd0, 32'h0},
      '{K_WR,    32'h0000_011C, 2'd2, 32'h0073_9002, 3'd0, 32'h0},
      '{K_FETCH, 32'h0000_0100, 2'd0, 32'h0,         3'd0, 32'd12},
      '{K_FETCH, 32'h0000_0106, 2'd1, 32'h0,         3'd0, 32'd10}, // PC bit 1 set
      '{K_RD,    32'h0000_0104, 2'd2, 32'h0,         3'd7, 32'h852A_0010},
      '{K_FETCH, 32'h0000_0102, 2'd2, 32'h0,         3'd0, 32'd12},
      '{K_FETCH, 32'h0000_010E, 2'd1, 32'h0,         3'd0, 32'd8}
   };

   logic                 clk;
   logic                 rst_n;
   logic                 exu_flush_final;
   logic [31:1]          exu_flush_path_final;
   logic                 dec_i0_decode_d;
   dma_req_t             dma_req;
   logic                 iccm_dma_rvalid;
   logic [31:0]          iccm_dma_rdata;
   logic [TW-1:0]        iccm_dma_rtag;
   logic                 ifu_i0_valid;
   logic [31:0]          ifu_i0_instr;
   logic [31:1]          ifu_i0_pc;
   logic                 ifu_i0_pc4;

   logic [31:0]          shadow [ICCM_WORDS];               // Expected ICCM contents
   logic [31:0]          exp_instr [$];
   logic [31:0]          exp_pc [$];                        // Byte PCs
   logic                 exp_pc4 [$];
   logic                 fetch_done;

   ifu_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ********************
   // Helpers
   // ********************

   task automatic report_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
      $display("error: time %0t signal %s expected %h actual %h", $time, sig, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
   endtask

   function automatic logic [31:0] fill_word(input logic [31:0] idx);
      return {idx[7:0] ^ 8'h5A, ~idx[7:0], idx[7:0], idx[7:0] ^ 8'hC3};
   endfunction

   function automatic logic [15:0] shadow_half(input logic [31:0] pc);
      logic [31:0] w;
      w = shadow[pc[`IFU_ICCM_AW+1:2]];
      return pc[1] ? w[31:16] : w[15:0];                    // Upper parcel at PC + 2
   endfunction

   function automatic logic next_decode(input logic [1:0] mode);
      if (mode == 2'd0) begin
         return 1'b1;
      end
      return ($urandom % 4) != 0;                           // Stall about a quarter
   endfunction

   task automatic dma_write(input logic [31:0] addr, input logic [1:0] size,
                            input logic [31:0] data);
      logic [`IFU_ICCM_AW-1:0] idx;
      idx = addr[`IFU_ICCM_AW+1:2];
      @(posedge clk);
      dma_req <= '{valid: 1'b1, write: 1'b1, addr: addr, size: size, tag: '0, wdata: data};
      case (size)
         2'd0:    shadow[idx][8 * addr[1:0] +: 8] = data[7:0];
         2'd1:    shadow[idx][16 * addr[1] +: 16] = data[15:0];
         default: shadow[idx] = data;
      endcase
      @(posedge clk);
      dma_req.valid <= 1'b0;                                // Single-cycle strobe
   endtask

   task automatic dma_read(input logic [31:0] addr, input logic [TW-1:0] tag,
                           output logic [31:0] data);
      logic [31:0] exp_word;
      exp_word = shadow[addr[`IFU_ICCM_AW+1:2]];
      @(posedge clk);
      dma_req <= '{valid: 1'b1, write: 1'b0, addr: addr, size: 2'd2, tag: tag, wdata: '0};
      @(negedge clk);
      assert (!iccm_dma_rvalid) else report_error("iccm_dma_rvalid", 32'd0, 32'd1);
      @(posedge clk);
      dma_req.valid <= 1'b0;
      @(negedge clk);                                       // Exactly one cycle later
      assert (iccm_dma_rvalid) else report_error("iccm_dma_rvalid", 32'd1, 32'd0);
      assert (iccm_dma_rtag == tag)
         else report_error("iccm_dma_rtag", 32'(tag), 32'(iccm_dma_rtag));
      assert (iccm_dma_rdata == exp_word)
         else report_error("iccm_dma_rdata", exp_word, iccm_dma_rdata);
      data = iccm_dma_rdata;
   endtask

   // ********************
   // Reference stream
   // ********************

   task automatic build_expected(input logic [31:0] target, input int count);
      logic [31:0] pc;
      logic [15:0] lo;
      exp_instr.delete();
      exp_pc.delete();
      exp_pc4.delete();
      pc = target;
      for (int n = 0; n < count; n++) begin
         lo = shadow_half(pc);
         exp_pc.push_back(pc);
         if (lo[1:0] == 2'b11) begin                        // Full-length instruction
            exp_instr.push_back({shadow_half(pc + 32'd2), lo});
            exp_pc4.push_back(1'b1);
            pc = pc + 32'd4;
         end else begin
            exp_instr.push_back({16'h0000, lo});
            exp_pc4.push_back(1'b0);
            pc = pc + 32'd2;
         end
      end
   endtask

   task automatic check_instr(input int n);
      assert (ifu_i0_instr == exp_instr[n])
         else report_error("ifu_i0_instr", exp_instr[n], ifu_i0_instr);
      assert (ifu_i0_pc == exp_pc[n][31:1])
         else report_error("ifu_i0_pc", exp_pc[n], {ifu_i0_pc, 1'b0});
      assert (ifu_i0_pc4 == exp_pc4[n])
         else report_error("ifu_i0_pc4", 32'(exp_pc4[n]), 32'(ifu_i0_pc4));
   endtask

   task automatic run_fetch(input logic [31:0] target, input logic [1:0] mode, input int count);
      int          taken;
      int          reads;
      logic [31:0] rd;
      build_expected(target, count);
      taken      = 0;
      reads      = 0;
      fetch_done = 1'b0;
      @(posedge clk);
      exu_flush_final      <= 1'b1;
      exu_flush_path_final <= target[31:1];
      dec_i0_decode_d      <= 1'b0;
      @(posedge clk);
      exu_flush_final <= 1'b0;
      dec_i0_decode_d <= next_decode(mode);
      fork
         begin
            while (taken < count) begin
               @(negedge clk);
               if (ifu_i0_valid && dec_i0_decode_d) begin   // Taken at next edge
                  check_instr(taken);
                  taken++;
               end
               if (taken < count) begin
                  @(posedge clk);
                  dec_i0_decode_d <= next_decode(mode);
               end
            end
            fetch_done = 1'b1;
         end
         begin
            while (mode == 2'd2 && !fetch_done) begin
               repeat (3) @(posedge clk);
               if (!fetch_done) begin
                  dma_read(target + 32'(4 * (reads % 8)), TW'(reads), rd);
                  reads++;
               end
            end
         end
      join
   endtask

   task automatic apply_step(input step_t s);
      logic [31:0] rd;
      case (s.kind)
         K_WR: dma_write(s.addr, s.size, s.data);
         K_RD: begin
            dma_read(s.addr, s.tag, rd);
            assert (rd == s.expv) else report_error("iccm_dma_rdata", s.expv, rd);
         end
         K_FETCH: run_fetch(s.addr, s.size, int'(s.expv));
         default: begin
            $display("step table holds an unknown step kind %0d", s.kind);
            $display("TEST RESULT: FAIL");
            $fatal(1, "bad step");
         end
      endcase
   endtask

   // ********************
   // Main sequence
   // ********************

   initial begin
      void'($urandom(32'h4829_5505));
      rst_n                <= 1'b0;
      exu_flush_final      <= 1'b0;
      exu_flush_path_final <= '0;
      dec_i0_decode_d      <= 1'b0;
      dma_req              <= '0;
      repeat (RESET_CYC) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < ICCM_WORDS; i++) begin
         dma_write(32'(i) << 2, 2'd2, fill_word(32'(i)));  // Known contents everywhere
      end
      for (int i = 0; i < NSTEPS; i++) begin
         apply_step(STEPS[i]);
      end
      @(posedge clk);
      $display("TEST RESULT: PASS");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("watchdog expired before all table steps completed");
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
   end

endmodule

// ==== files.f ====
+incdir+common
common/ifu_pkg.sv
hw/fetch/ifu_ifc_ctl.sv
hw/fetch/ifu_aln_ctl.sv
hw/iccm/iccm_arb.sv
hw/iccm/iccm_mem.sv
hw/ifu_top.sv
dv/ifu_chk.sv
dv/ifu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module ifu_tb --Mdir build -o ifu_sim -f files.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out="$(./build/ifu_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
   exit 0
else
   exit 1
fi
